// ==== run_sim.sh ====
#!/bin/sh
# Builds the tiny45 testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tiny45_cpu_tb -f tiny45_cpu.f -o sim_tiny45
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tiny45 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// ==== tiny45_bus_pkg.sv ====
// Bus definitions for tiny45.
// Fetch and data address types, access size codes, nibble sequencing.
`default_nettype none

package tiny45_bus_pkg;

    typedef logic [15:0] halfword_t;
    typedef logic [23:1] iaddr_t;   // Halfword address.
    typedef logic [27:0] daddr_t;

    typedef logic [1:0]  size_code_t;

    localparam size_code_t SIZE_WORD = 2'b10;
    localparam size_code_t SIZE_NONE = 2'b11;

    typedef logic [2:0]  nibble_idx_t;
    typedef logic [3:0]  nibble_t;

    localparam nibble_idx_t LAST_NIBBLE = 3'd7;

endpackage

`default_nettype wire

// ==== tiny45_cpu.f ====
tiny45_pkg.sv
tiny45_bus_pkg.sv
tiny45_fetch_buffer.sv
tiny45_decoder.sv
tiny45_regfile.sv
tiny45_exec.sv
tiny45_cpu.sv
tiny45_cpu_tb.sv

// ==== tiny45_cpu.sv ====
// tiny45 top level with the nibble counter.
// Connects fetch buffer, decoder, register file and exec.
`timescale 1ns/1ps
`default_nettype none

module tiny45_cpu import tiny45_pkg::*, tiny45_bus_pkg::*; (
    input  wire            clk,
    input  wire            rstn,

    output iaddr_t         instr_addr,
    output logic           instr_fetch_restart,
    output logic           instr_fetch_stall,
    input  wire            instr_fetch_started,
    input  wire            instr_fetch_stopped,
    input  wire halfword_t instr_data,
    input  wire            instr_ready,

    output daddr_t         data_addr,
    output size_code_t     data_write_n,
    output size_code_t     data_read_n,
    output word_t          data_out,
    input  wire            data_ready
);

    nibble_idx_t    counter;
    word_t          instr_word;
    logic           avail;
    logic           consume;
    logic           complete;
    decoded_instr_t dec;
    logic           instr_valid;
    nibble_t        rs1_nib;
    nibble_t        rs2_nib;
    nibble_t        rd_nib;
    logic           rd_we;

    // Free running, one pass is eight cycles.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
        end else begin
            counter <= counter + 3'd1;
        end
    end

    tiny45_fetch_buffer i_fetch (
        .clk                 (clk),
        .rstn                (rstn),
        .instr_data          (instr_data),
        .instr_ready         (instr_ready),
        .instr_fetch_started (instr_fetch_started),
        .instr_fetch_stopped (instr_fetch_stopped),
        .consume             (consume),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall),
        .instr_word          (instr_word),
        .avail               (avail)
    );

    tiny45_decoder i_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .instr_word  (instr_word),
        .avail       (avail),
        .complete    (complete),
        .dec         (dec),
        .instr_valid (instr_valid),
        .consume     (consume)
    );

    tiny45_regfile i_regfile (
        .clk     (clk),
        .rstn    (rstn),
        .counter (counter),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rd      (dec.rd),
        .rd_nib  (rd_nib),
        .rd_we   (rd_we),
        .rs1_nib (rs1_nib),
        .rs2_nib (rs2_nib)
    );

    tiny45_exec i_exec (
        .clk          (clk),
        .rstn         (rstn),
        .counter      (counter),
        .dec          (dec),
        .instr_valid  (instr_valid),
        .rs1_nib      (rs1_nib),
        .rs2_nib      (rs2_nib),
        .data_ready   (data_ready),
        .rd_nib       (rd_nib),
        .rd_we        (rd_we),
        .data_addr    (data_addr),
        .data_write_n (data_write_n),
        .data_read_n  (data_read_n),
        .data_out     (data_out),
        .complete     (complete)
    );

endmodule

`default_nettype wire

// ==== tiny45_cpu_tb.sv ====
// Testbench for the tiny45 CPU.
// Instruction and data memory models, program loading from the tests file, store checks.
`timescale 1ns/1ps
`default_nettype none

module tiny45_cpu_tb import tiny45_pkg::*, tiny45_bus_pkg::*;;

    logic       clk;
    logic       rstn;
    halfword_t  instr_data;
    logic       instr_ready;
    logic       instr_fetch_started;
    logic       instr_fetch_stopped;
    logic       data_ready;
    iaddr_t     instr_addr;
    logic       instr_fetch_restart;
    logic       instr_fetch_stall;
    daddr_t     data_addr;
    size_code_t data_write_n;
    size_code_t data_read_n;
    word_t      data_out;

    halfword_t  imem [1024];
    string      exp_test [$];
    string      exp_name [$];
    daddr_t     exp_addr [$];
    word_t      exp_data [$];
    string      test_name;

    int          mismatches = 0;
    int          other_errors = 0;
    int          stores_seen = 0;
    int          n_prog = 0;
    int          limit;
    int          cycles = 0;
    int          gap_left;
    int          ready_wait;
    logic [31:0] rng = 32'h8d58;
    iaddr_t      fetch_addr;
    logic        start_sent;
    logic        prev_strobe;

    tiny45_cpu tiny45_cpu_inst (
        .clk                 (clk),
        .rstn                (rstn),
        .instr_addr          (instr_addr),
        .instr_fetch_restart (instr_fetch_restart),
        .instr_fetch_stall   (instr_fetch_stall),
        .instr_fetch_started (instr_fetch_started),
        .instr_fetch_stopped (instr_fetch_stopped),
        .instr_data          (instr_data),
        .instr_ready         (instr_ready),
        .data_addr           (data_addr),
        .data_write_n        (data_write_n),
        .data_read_n         (data_read_n),
        .data_out            (data_out),
        .data_ready          (data_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Past the program every pair is ADDI x0, x0 with the address as immediate.
    task automatic fill_imem();
        logic [10:0] i;
        i = '0;
        while (i < 11'd1024) begin
            if (i[0]) begin
                imem[i[9:0]] = {2'b00, i[9:0], 4'b0000};
            end else begin
                imem[i[9:0]] = 16'h0013;
            end
            i = i + 11'd1;
        end
    endtask

    task automatic load_tests();
        int        fd;
        int        n;
        string     line;
        string     name;
        halfword_t lo;
        halfword_t hi;
        daddr_t    addr;
        word_t     data;
        byte       c;
        fd = $fopen("tiny45_cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file tiny45_cpu_tests.txt");
            other_errors++;
            return;
        end
        test_name = "none";
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                c = line.getc(0);
                case (c)
                    "T": n = $sscanf(line, "T %s", test_name);
                    "P": begin
                        n = $sscanf(line, "P %h %h", lo, hi);
                        if (n == 2) begin
                            imem[10'(n_prog)]     = lo; // Low halfword first.
                            imem[10'(n_prog + 1)] = hi;
                            n_prog = n_prog + 2;
                        end else begin
                            $display("Malformed program line in tests file: %s", line);
                            other_errors++;
                        end
                    end
                    "E": begin
                        n = $sscanf(line, "E %s %h %h", name, addr, data);
                        if (n == 3) begin
                            exp_test.push_back(test_name);
                            exp_name.push_back(name);
                            exp_addr.push_back(addr);
                            exp_data.push_back(data);
                        end else begin
                            $display("Malformed store line in tests file: %s", line);
                            other_errors++;
                        end
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic check_store(input daddr_t addr, input word_t data);
        int k;
        k = stores_seen;
        if (k >= exp_addr.size()) begin
            $display("Unexpected extra store of %08h at address %07h", data, addr);
            other_errors++;
        end else begin
            assert (addr == exp_addr[k]) else begin
                $display("MISMATCH %s/%s address expected %07h actual %07h",
                         exp_test[k], exp_name[k], exp_addr[k], addr);
                mismatches++;
            end
            assert (data == exp_data[k]) else begin
                $display("MISMATCH %s/%s data expected %08h actual %08h",
                         exp_test[k], exp_name[k], exp_data[k], data);
                mismatches++;
            end
        end
        stores_seen++;
    endtask

    // Fetch source and data memory share one LCG.
    always @(posedge clk) begin
        if (!rstn) begin
            instr_ready         <= 1'b0;
            instr_fetch_started <= 1'b0;
            data_ready          <= 1'b0;
            fetch_addr  = '0;
            gap_left    = 0;
            ready_wait  = 0;
            start_sent  = 1'b0;
            prev_strobe = 1'b0;
        end else begin
            instr_fetch_started <= !start_sent; // Single pulse after reset.
            start_sent = 1'b1;

            if (instr_ready && !instr_fetch_restart) begin
                assert (instr_addr == fetch_addr) else begin
                    $display("Fetch address %06h differs from the halfword count %06h",
                             instr_addr, fetch_addr);
                    other_errors++;
                end
                fetch_addr = fetch_addr + 1'b1;
            end
            if (gap_left > 0) begin
                gap_left = gap_left - 1;
                instr_ready <= 1'b0;
            end else if (!instr_fetch_restart && !instr_fetch_stall) begin
                instr_ready <= 1'b1;
                instr_data  <= imem[fetch_addr[10:1]];
                rng = lcg_next(rng);
                gap_left = int'(rng[17:16]);
            end else begin
                instr_ready <= 1'b0;
            end

            data_ready <= 1'b0;
            if (ready_wait > 0) begin
                ready_wait = ready_wait - 1;
                if (ready_wait == 0) begin
                    data_ready <= 1'b1;
                end
            end
            assert (data_read_n == SIZE_NONE) else begin
                $display("Read strobe seen although loads are not supported");
                other_errors++;
            end
            assert (data_write_n == SIZE_NONE || data_write_n == SIZE_WORD) else begin
                $display("Write strobe carries an illegal size code %b", data_write_n);
                other_errors++;
            end
            if (data_write_n == SIZE_WORD) begin
                assert (!prev_strobe) else begin
                    $display("Write strobe held for more than one cycle");
                    other_errors++;
                end
                check_store(data_addr, data_out);
                rng = lcg_next(rng);
                ready_wait = int'(rng[19:16]) % 13; // 0 to 12 cycles.
                if (ready_wait == 0) begin
                    data_ready <= 1'b1;
                end
            end
            prev_strobe = (data_write_n == SIZE_WORD);
        end
    end

    initial begin
        clk                 = 1'b0;
        rstn                = 1'b0;
        instr_data          = '0;
        instr_ready         = 1'b0;
        instr_fetch_started = 1'b0;
        instr_fetch_stopped = 1'b0;
        data_ready          = 1'b0;
        fill_imem();
        load_tests();
        limit = 40 * n_prog + 200;

        repeat (3) @(posedge clk);
        assert (data_write_n == SIZE_NONE && data_read_n == SIZE_NONE &&
                instr_fetch_restart) else begin
            $display("Strobes idle and fetch restart high were expected in reset");
            other_errors++;
        end
        rstn <= 1'b1;

        while (stores_seen < exp_addr.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < exp_addr.size()) begin
            $display("Timeout after %0d cycles with %0d expected stores missing",
                     cycles, exp_addr.size() - stores_seen);
            other_errors++;
        end
        repeat (48) @(posedge clk); // Window for stray stores.

        $display("Errors: %0d mismatches, %0d other, stores seen %0d of %0d expected",
                 mismatches, other_errors, stores_seen, exp_addr.size());
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tiny45_cpu_tests.txt ====
# T <name> starts a test. P <lo> <hi> is one instruction as two hex halfwords, low first.
# E <name> <addr> <data> is the next expected store, 28-bit address and 32-bit data in hex.
T const
P 50b7 1234  # lui  x1, 0x12345
P 8093 6780  # addi x1, x1, 0x678
P 0113 1000  # addi x2, x0, 0x100
P 2023 0011  # sw   x1, 0(x2)
P 0193 fff0  # addi x3, x0, -1
P 2e23 fe11  # sw   x1, -4(x2)
E sw_base     0000100 12345678
E sw_negoff   00000fc 12345678
T alu
P 0213 0010  # addi x4, x0, 1
P 82b3 0041  # add  x5, x3, x4
P 2423 0051  # sw   x5, 8(x2)
P 03b3 4010  # sub  x7, x0, x1
P f433 0070  # and  x8, x1, x7
P e4b3 0070  # or   x9, x1, x7
P c533 0070  # xor  x10, x1, x7
P 2823 0071  # sw   x7, 16(x2)
P 2a23 0081  # sw   x8, 20(x2)
P 2c23 0091  # sw   x9, 24(x2)
P 2e23 00a1  # sw   x10, 28(x2)
E add_carry   0000108 00000000
E sub_borrow  0000110 edcba988
E and_reg     0000114 00000008
E or_reg      0000118 fffffff8
E xor_reg     000011c fffffff0
T x0
P 0013 0550  # addi x0, x0, 0x55
P e037 abcd  # lui  x0, 0xabcde
P 0733 0040  # add  x14, x0, x4
P 2423 0201  # sw   x0, 40(x2)
P 2623 02e1  # sw   x14, 44(x2)
E x0_reads    0000128 00000000
E x0_source   000012c 00000001
T nop
P 1213 0042  # slli x4, x4, 4
P 2203 0001  # lw   x4, 0(x2)
P 0023 0031  # sb   x3, 0(x2)
P 026f 0000  # jal  x4, 0
P 2823 0241  # sw   x4, 48(x2)
E x4_kept     0000130 00000001
T chain
P 0793 7ff0  # addi x15, x0, 0x7ff
P 87b3 00f7  # add  x15, x15, x15
P 87b3 00f7  # add  x15, x15, x15
P 8793 0047  # addi x15, x15, 4
P 87b3 4017  # sub  x15, x15, x1
P c793 0ff7  # xori x15, x15, 0xff
P e793 5057  # ori  x15, x15, 0x505
P f793 f007  # andi x15, x15, -256
P 2a23 02f1  # sw   x15, 52(x2)
P afa3 fe17  # sw   x1, -1(x15)
E chain_end   0000134 edcbcd00
E chain_addr  dcbccff 12345678

// ==== tiny45_decoder.sv ====
// RV32E subset decoder and the decoded-instruction latch.
`timescale 1ns/1ps
`default_nettype none

module tiny45_decoder import tiny45_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    input  wire word_t instr_word,
    input  wire        avail,
    input  wire        complete,
    output decoded_instr_t dec,
    output logic       instr_valid,
    output logic       consume
);

    decoded_instr_t d;
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    word_t          imm_i;
    word_t          imm_s;
    word_t          imm_u;
    alu_op_e        f3_op;
    logic           f3_ok;

    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];

    assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
    assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
    assign imm_u = {instr_word[31:12], 12'h000};

    // Shared funct3 mapping for immediate and register forms.
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0; // Shifts and compares.
            end
        endcase
    end

    always_comb begin
        d     = '0; // Unknown opcodes fall out as NOP with rd of x0.
        d.rs1 = instr_word[18:15];
        d.rs2 = instr_word[23:20];
        case (opcode)
            OP_ALU_IMM: begin
                if (f3_ok) begin
                    d.cls    = CLS_ALU_IMM;
                    d.alu_op = f3_op;
                    d.rd     = instr_word[10:7];
                    d.imm    = imm_i;
                end
            end
            OP_ALU_REG: begin
                if (f3_ok && (!instr_word[30] || funct3 == F3_ADD)) begin
                    d.cls    = CLS_ALU_REG;
                    d.alu_op = instr_word[30] ? ALU_SUB : f3_op;
                    d.rd     = instr_word[10:7];
                end
            end
            OP_LUI: begin
                d.cls    = CLS_LUI;
                d.alu_op = ALU_PASS_B;
                d.rd     = instr_word[10:7];
                d.imm    = imm_u;
            end
            OP_STORE: begin
                if (funct3 == F3_SW) begin
                    d.cls    = CLS_STORE;
                    d.alu_op = ALU_ADD; // Address is rs1 + imm.
                    d.imm    = imm_s;
                end
            end
            default: ;
        endcase
    end

    assign consume = complete && avail;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec         <= '0;
            instr_valid <= 1'b0;
        end else if (complete) begin
            dec         <= d;
            instr_valid <= avail; // Bubble pass when the ring is short.
        end
    end

    a_nop_no_rd: assert property (@(posedge clk) disable iff (!rstn)
        dec.cls == CLS_NOP |-> dec.rd == '0);

endmodule

`default_nettype wire

// ==== tiny45_exec.sv ====
// Nibble-serial ALU and writeback.
// Store address and data assembly, write strobe and data_ready wait.
`timescale 1ns/1ps
`default_nettype none

module tiny45_exec import tiny45_pkg::*, tiny45_bus_pkg::*; (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire nibble_idx_t    counter,
    input  wire decoded_instr_t dec,
    input  wire                 instr_valid,
    input  wire nibble_t        rs1_nib,
    input  wire nibble_t        rs2_nib,
    input  wire                 data_ready,

    output nibble_t             rd_nib,
    output logic                rd_we,
    output daddr_t              data_addr,
    output size_code_t          data_write_n,
    output size_code_t          data_read_n,
    output word_t               data_out,
    output logic                complete
);

    typedef enum logic {
        EX_RUN,
        EX_WAIT
    } ex_state_e;

    ex_state_e  state;
    logic [4:0] bit_lo;
    logic       last;
    logic       is_store;
    logic       assemble;
    logic       carry_q;
    logic       carry_in;
    nibble_t    op_b;
    nibble_t    b_add;
    logic [4:0] sum;
    logic       ready_seen;
    daddr_t     addr_acc;

    assign bit_lo   = {counter, 2'b00};
    assign last     = (counter == LAST_NIBBLE);
    assign is_store = instr_valid && dec.cls == CLS_STORE;
    assign assemble = is_store && state == EX_RUN;

    assign op_b  = (dec.cls == CLS_ALU_REG) ? rs2_nib : dec.imm[bit_lo +: 4];
    assign b_add = (dec.alu_op == ALU_SUB) ? ~op_b : op_b;

    // Borrow enters as carry-in of one on the first nibble.
    assign carry_in = (counter == '0) ? (dec.alu_op == ALU_SUB) : carry_q;
    assign sum      = {1'b0, rs1_nib} + {1'b0, b_add} + {4'b0000, carry_in};

    always_comb begin
        case (dec.alu_op)
            ALU_ADD, ALU_SUB: rd_nib = sum[3:0];
            ALU_AND:          rd_nib = rs1_nib & op_b;
            ALU_OR:           rd_nib = rs1_nib | op_b;
            ALU_XOR:          rd_nib = rs1_nib ^ op_b;
            default:          rd_nib = op_b;
        endcase
    end

    assign rd_we = instr_valid && (dec.cls == CLS_ALU_IMM || dec.cls == CLS_ALU_REG ||
                                   dec.cls == CLS_LUI);

    // Stores hold the pipeline until data_ready has been seen.
    assign complete = last && ((state == EX_RUN) ? !is_store : (ready_seen || data_ready));

    assign data_read_n = SIZE_NONE; // No loads.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            carry_q <= 1'b0;
        end else begin
            carry_q <= sum[4];
        end
    end

    always_ff @(posedge clk) begin
        if (assemble) begin
            data_out[bit_lo +: 4] <= rs2_nib;
            if (!last) begin
                addr_acc[bit_lo +: 4] <= sum[3:0]; // Top nibble is dropped.
            end
            if (last) begin
                data_addr <= addr_acc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= EX_RUN;
            ready_seen   <= 1'b0;
            data_write_n <= SIZE_NONE;
        end else begin
            data_write_n <= SIZE_NONE;
            case (state)
                EX_RUN: begin
                    if (assemble && last) begin
                        state        <= EX_WAIT;
                        ready_seen   <= 1'b0;
                        data_write_n <= SIZE_WORD; // Strobe for one cycle.
                    end
                end
                EX_WAIT: begin
                    if (complete) begin
                        state <= EX_RUN;
                    end else begin
                        ready_seen <= ready_seen | data_ready;
                    end
                end
                default: state <= EX_RUN;
            endcase
        end
    end

    a_write_code: assert property (@(posedge clk) disable iff (!rstn)
        data_write_n == SIZE_NONE || data_write_n == SIZE_WORD);

endmodule

`default_nettype wire

// ==== tiny45_fetch_buffer.sv ====
// Four-halfword instruction prefetch ring.
// Fetch address generation, stall and restart.
`timescale 1ns/1ps
`default_nettype none

module tiny45_fetch_buffer import tiny45_pkg::*, tiny45_bus_pkg::*; (
    input  wire            clk,
    input  wire            rstn,

    input  wire halfword_t instr_data,
    input  wire            instr_ready,
    input  wire            instr_fetch_started,
    input  wire            instr_fetch_stopped,
    input  wire            consume,

    output iaddr_t         instr_addr,
    output logic           instr_fetch_restart,
    output logic           instr_fetch_stall,
    output word_t          instr_word,
    output logic           avail
);

    halfword_t  ring [4];

    // Offsets carry one wrap bit so a full ring differs from an empty one.
    logic [2:0] wr_off;
    logic [2:0] pc_off;
    logic [2:0] fill;
    logic [2:0] next_fill;
    logic       running;
    logic       write;

    assign fill      = wr_off - pc_off;
    assign write     = instr_ready && running;
    assign next_fill = fill + {2'b00, write} - (consume ? 3'd2 : 3'd0);

    assign avail = (fill >= 3'd2); // A whole 32-bit instruction.

    // Looks one edge ahead so a source sampling on the edge holds off in time.
    assign instr_fetch_stall   = (next_fill == 3'd4);
    assign instr_fetch_restart = !running;

    assign instr_word = {ring[pc_off[1:0] + 2'd1], ring[pc_off[1:0]]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_off     <= '0;
            pc_off     <= '0;
            running    <= 1'b0;
            instr_addr <= '0;
        end else begin
            if (instr_fetch_started) begin
                running <= 1'b1;
            end else if (instr_fetch_stopped) begin
                running <= 1'b0;
            end

            if (write) begin
                wr_off     <= wr_off + 3'd1;
                instr_addr <= instr_addr + 1'b1;
            end

            if (consume) begin
                pc_off <= pc_off + 3'd2; // Two halfwords per instruction.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ring[wr_off[1:0]] <= instr_data;
        end
    end

    // The source has to honor stall.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        write |-> fill != 3'd4);

    // Decoder only takes an instruction that is fully buffered.
    a_consume_avail: assert property (@(posedge clk) disable iff (!rstn)
        consume |-> avail);

endmodule

`default_nettype wire

// ==== tiny45_pkg.sv ====
// ISA definitions for the tiny45 RV32E subset.
// Opcodes, register and word types, ALU operations, decoded instruction.
`default_nettype none

package tiny45_pkg;

    localparam int NUM_REGS = 16;

    typedef logic [3:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // Major opcodes that are kept.
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OP_ALU_REG = 7'b0110011;
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_STORE   = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SW  = 3'b010; // Word store only.
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_LUI,
        CLS_STORE
    } instr_class_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        word_t        imm;
    } decoded_instr_t;

endpackage

`default_nettype wire

// ==== tiny45_regfile.sv ====
// Sixteen 32-bit registers with nibble-serial read and write ports.
`timescale 1ns/1ps
`default_nettype none

module tiny45_regfile import tiny45_pkg::*, tiny45_bus_pkg::*; (
    input  wire              clk,
    input  wire              rstn,
    input  wire nibble_idx_t counter,
    input  wire reg_idx_t    rs1,
    input  wire reg_idx_t    rs2,
    input  wire reg_idx_t    rd,
    input  wire nibble_t     rd_nib,
    input  wire              rd_we,
    output nibble_t          rs1_nib,
    output nibble_t          rs2_nib
);

    word_t      regs [NUM_REGS];
    logic [4:0] bit_lo;

    assign bit_lo = {counter, 2'b00};

    // Nibble k is read in the cycle before it is overwritten,
    // so rd == rs still sees the old value for the whole pass.
    assign rs1_nib = (rs1 == '0) ? '0 : regs[rs1][bit_lo +: 4];
    assign rs2_nib = (rs2 == '0) ? '0 : regs[rs2][bit_lo +: 4];

    always_ff @(posedge clk) begin
        if (rstn && rd_we && rd != '0) begin
            regs[rd][bit_lo +: 4] <= rd_nib; // x0 is never written.
        end
    end

endmodule

`default_nettype wire
